// File: src/ap_cache_pkg.sv
`default_nettype none

package ap_cache_pkg;

    // data word and column slice
    typedef logic [15:0] word_t;
    typedef logic [15:0] col_t;

    // memory and jump addresses
    typedef logic [15:0] maddr_t;
    typedef logic [27:0] jaddr_t;

    // bit position for column access
    typedef logic [3:0] bit_sel_t;

    typedef enum logic [2:0] {
        row_load,
        row_store,
        col_load,
        col_store,
        flush,
        jump_load
    } cache_op_e;

    typedef enum logic {
        id_cache,
        id_jump
    } req_id_e;

    typedef struct packed {
        cache_op_e op;
        maddr_t    addr;
        bit_sel_t  bit_sel;
        word_t     row;
        col_t      col;
    } cache_cmd_t;

    typedef struct packed {
        logic    write;
        maddr_t  addr;
        word_t   wdata;
        req_id_e id;
    } mem_req_t;

    typedef struct packed {
        word_t   rdata;
        req_id_e id;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: src/burst_ram.sv
`timescale 1ns/1ps
`default_nettype none

module burst_ram
    import ap_cache_pkg::*;
#(
    parameter int mem_words   = 4096,
    parameter int queue_depth = 2
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        req_valid,
    input  wire        mem_req_t req,
    output logic       rsp_valid,
    output mem_rsp_t   rsp,
    output logic       credit_ret
);

    localparam int aw = $clog2(mem_words);
    localparam int pw = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cw = $clog2(queue_depth + 1);

    word_t          mem [mem_words];
    mem_req_t       queue [queue_depth];
    mem_req_t       head;
    logic [pw-1:0]  wr_ptr;
    logic [pw-1:0]  rd_ptr;
    logic [cw-1:0]  count;
    logic           pop;
    logic           full;

    function automatic logic [pw-1:0] ptr_next(input logic [pw-1:0] p);
        return (p == pw'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    initial
    begin
        for (int i = 0; i < mem_words; i++)
            mem[i] = '0;
    end

    assign head       = queue[rd_ptr];
    assign pop        = (count != '0);
    assign full       = (count == cw'(queue_depth));
    assign credit_ret = pop;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (req_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            count     <= count + cw'(req_valid) - cw'(pop);
            rsp_valid <= pop && !head.write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
            queue[wr_ptr] <= req;
        // one-stage read register
        if (pop && !head.write)
        begin
            rsp.rdata <= mem[head.addr[aw-1:0]];
            rsp.id    <= head.id;
        end
    end

    always @(posedge clk)
    begin
        if (pop && head.write)
            mem[head.addr[aw-1:0]] <= head.wdata;
    end

    no_push_full: assert property (
        @(posedge clk) disable iff (!rst) req_valid |-> !full);

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import ap_cache_pkg::*;
#(
    parameter int queue_depth = 2
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        cache_valid,
    input  wire        mem_req_t cache_req,
    output logic       cache_grant,
    input  wire        jump_valid,
    input  wire        mem_req_t jump_req,
    output logic       jump_grant,
    output logic       ram_valid,
    output mem_req_t   ram_req,
    input  wire        credit_ret
);

    localparam int cred_w = $clog2(queue_depth + 1);

    logic [cred_w-1:0] credits;
    logic              prio_jump;
    logic              has_credit;

    assign has_credit = (credits != '0);

    // the loser of the last contest wins the next one
    assign cache_grant = has_credit && cache_valid && (!jump_valid || !prio_jump);
    assign jump_grant  = has_credit && jump_valid && (!cache_valid || prio_jump);

    assign ram_valid = cache_grant || jump_grant;
    assign ram_req   = jump_grant ? jump_req : cache_req;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            credits   <= cred_w'(queue_depth);
            prio_jump <= 1'b0;
        end
        else
        begin
            case ({ram_valid, credit_ret})
                2'b10:
                    credits <= credits - 1'b1;
                2'b01:
                    credits <= credits + 1'b1;
                default:
                    ;
            endcase
            if (cache_grant)
                prio_jump <= 1'b1;
            else if (jump_grant)
                prio_jump <= 1'b0;
        end
    end

    // more returns than grants would show up here
    credit_bound: assert property (
        @(posedge clk) disable iff (!rst) credits <= cred_w'(queue_depth));

    grant_onehot: assert property (
        @(posedge clk) disable iff (!rst) !(cache_grant && jump_grant));

endmodule

`default_nettype wire

// File: src/jump_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module jump_fetch
    import ap_cache_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        start,
    input  wire        maddr_t addr,
    output logic       done,
    output jaddr_t     jmp,
    output logic       req_valid,
    output mem_req_t   req,
    input  wire        grant,
    input  wire        mem_valid,
    input  wire        mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        jf_idle,
        jf_issue,
        jf_wait
    } state_e;

    state_e state;
    maddr_t addr_q;
    logic   rsp_hit;

    // only responses tagged for this requester
    assign rsp_hit   = (state == jf_wait) && mem_valid && (mem_rsp.id == id_jump);
    assign req_valid = (state == jf_issue);

    always_comb
    begin
        req.write = 1'b0;
        req.addr  = addr_q;
        req.wdata = '0;
        req.id    = id_jump;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= jf_idle;
            done  <= 1'b0;
            jmp   <= '0;
        end
        else
        begin
            done <= rsp_hit;
            case (state)
                jf_idle:
                begin
                    if (start)
                    begin
                        state <= jf_issue;
                        jmp   <= '0;
                    end
                end
                jf_issue:
                begin
                    if (grant)
                        state <= jf_wait;
                end
                jf_wait:
                begin
                    if (rsp_hit)
                    begin
                        state <= jf_idle;
                        jmp   <= jaddr_t'(mem_rsp.rdata);
                    end
                end
                default:
                    state <= jf_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && (state == jf_idle))
            addr_q <= addr;
    end

endmodule

`default_nettype wire

// File: src/data_cache.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache
    import ap_cache_pkg::*;
#(
    parameter int line_words = 16
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        start,
    input  wire        cache_cmd_t cmd,
    output logic       done,
    output word_t      row_data,
    output col_t       col_data,
    output logic       req_valid,
    output mem_req_t   req,
    input  wire        grant,
    input  wire        mem_valid,
    input  wire        mem_rsp_t mem_rsp
);

    localparam int idx_w = $clog2(line_words);
    localparam int cnt_w = idx_w + 1;
    localparam int tag_w = $bits(maddr_t) - idx_w;

    typedef enum logic [2:0] {
        idle,
        write_back,
        fill,
        access,
        complete
    } state_e;

    state_e           state;
    state_e           state_n;
    cache_cmd_t       cmd_q;
    cache_cmd_t       cur;
    word_t            line [line_words];
    logic [tag_w-1:0] tag;
    logic             line_valid;
    logic             dirty;
    logic [idx_w-1:0] wb_cnt;
    logic [cnt_w-1:0] issue_cnt;
    logic [cnt_w-1:0] rcv_cnt;
    logic [idx_w-1:0] cur_idx;
    logic             hit;
    logic             do_access;
    logic             fill_wr;
    logic             wb_last;
    logic             fill_last;

    // live command while idle, latched copy afterwards
    assign cur       = (state == idle) ? cmd : cmd_q;
    assign cur_idx   = cur.addr[idx_w-1:0];
    assign hit       = line_valid && (cmd.addr[$bits(maddr_t)-1:idx_w] == tag);
    assign fill_wr   = (state == fill) && mem_valid && (mem_rsp.id == id_cache);
    assign wb_last   = (state == write_back) && grant && (wb_cnt == idx_w'(line_words - 1));
    assign fill_last = fill_wr && (rcv_cnt == cnt_w'(line_words - 1));
    assign do_access = (state == access) ||
                       ((state == idle) && start && hit && (cmd.op != flush));
    assign done      = (state == complete);

    always_comb
    begin
        state_n = state;
        case (state)
            idle:
            begin
                if (start)
                begin
                    if (cmd.op == flush)
                        state_n = dirty ? write_back : complete;
                    else if (hit)
                        state_n = complete;
                    else if (dirty)
                        state_n = write_back;
                    else
                        state_n = fill;
                end
            end
            write_back:
            begin
                if (wb_last)
                    state_n = (cmd_q.op == flush) ? complete : fill;
            end
            fill:
            begin
                if (fill_last)
                    state_n = access;
            end
            access:
                state_n = complete;
            default:
                state_n = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= idle;
            tag        <= '0;
            line_valid <= 1'b0;
            dirty      <= 1'b0;
            wb_cnt     <= '0;
            issue_cnt  <= '0;
            rcv_cnt    <= '0;
        end
        else
        begin
            state <= state_n;
            if (state == idle)
            begin
                wb_cnt    <= '0;
                issue_cnt <= '0;
                rcv_cnt   <= '0;
            end
            if ((state == write_back) && grant)
                wb_cnt <= wb_cnt + 1'b1;
            if ((state == fill) && req_valid && grant)
                issue_cnt <= issue_cnt + 1'b1;
            if (fill_wr)
                rcv_cnt <= rcv_cnt + 1'b1;
            if (wb_last)
                dirty <= 1'b0;
            // new line base taken on the way into fill
            if ((state_n == fill) && (state != fill))
            begin
                tag        <= cur.addr[$bits(maddr_t)-1:idx_w];
                line_valid <= 1'b0;
                dirty      <= 1'b0;
            end
            if (fill_last)
                line_valid <= 1'b1;
            if (do_access && ((cur.op == row_store) || (cur.op == col_store)))
                dirty <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && (state == idle))
            cmd_q <= cmd;
        if (fill_wr)
            line[rcv_cnt[idx_w-1:0]] <= mem_rsp.rdata;
        if (do_access)
        begin
            case (cur.op)
                row_load:
                    row_data <= line[cur_idx];
                row_store:
                    line[cur_idx] <= cur.row;
                col_load:
                    for (int j = 0; j < line_words; j++)
                        col_data[j] <= line[j][cur.bit_sel];
                col_store:
                    for (int j = 0; j < line_words; j++)
                        line[j][cur.bit_sel] <= cur.col[j];
                default:
                    ;
            endcase
        end
    end

    // writes during write-back, reads during fill
    assign req_valid = (state == write_back) ||
                       ((state == fill) && (issue_cnt != cnt_w'(line_words)));

    always_comb
    begin
        req.write = (state == write_back);
        req.addr  = (state == write_back) ? {tag, wb_cnt} : {tag, issue_cnt[idx_w-1:0]};
        req.wdata = line[wb_cnt];
        req.id    = id_cache;
    end

    start_only_idle: assert property (
        @(posedge clk) disable iff (!rst) start |-> (state == idle));

    // a fill word only answers a read already issued, never more than line_words of them
    fill_in_range: assert property (
        @(posedge clk) disable iff (!rst) fill_wr |-> (rcv_cnt < issue_cnt));

endmodule

`default_nettype wire

// File: src/ap_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module ap_cache_top
    import ap_cache_pkg::*;
#(
    parameter int line_words  = 16,
    parameter int mem_words   = 4096,
    parameter int queue_depth = 2
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire        cmd_valid,
    input  wire        cache_cmd_t cmd,
    output logic       cmd_rdy,
    output logic       rsp_valid,
    output word_t      rsp_row,
    output col_t       rsp_col,
    output jaddr_t     rsp_jmp
);

    logic     busy;
    logic     accept;
    logic     is_jump;
    logic     dc_start;
    logic     dc_done;
    logic     jf_start;
    logic     jf_done;
    logic     dc_req_valid;
    logic     dc_grant;
    mem_req_t dc_req;
    logic     jf_req_valid;
    logic     jf_grant;
    mem_req_t jf_req;
    logic     ram_valid;
    mem_req_t ram_req;
    logic     mem_valid;
    mem_rsp_t mem_rsp;
    logic     credit_ret;

    // one command in flight
    assign cmd_rdy   = !busy;
    assign accept    = cmd_valid && cmd_rdy;
    assign is_jump   = (cmd.op == jump_load);
    assign dc_start  = accept && !is_jump;
    assign jf_start  = accept && is_jump;
    assign rsp_valid = dc_done || jf_done;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            busy <= 1'b0;
        else if (accept)
            busy <= 1'b1;
        else if (rsp_valid)
            busy <= 1'b0;
    end

    data_cache #(
        .line_words (line_words)
    ) i_data_cache (
        .clk       (clk),
        .rst       (rst),
        .start     (dc_start),
        .cmd       (cmd),
        .done      (dc_done),
        .row_data  (rsp_row),
        .col_data  (rsp_col),
        .req_valid (dc_req_valid),
        .req       (dc_req),
        .grant     (dc_grant),
        .mem_valid (mem_valid),
        .mem_rsp   (mem_rsp)
    );

    jump_fetch i_jump_fetch (
        .clk       (clk),
        .rst       (rst),
        .start     (jf_start),
        .addr      (cmd.addr),
        .done      (jf_done),
        .jmp       (rsp_jmp),
        .req_valid (jf_req_valid),
        .req       (jf_req),
        .grant     (jf_grant),
        .mem_valid (mem_valid),
        .mem_rsp   (mem_rsp)
    );

    mem_arbiter #(
        .queue_depth (queue_depth)
    ) i_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .cache_valid (dc_req_valid),
        .cache_req   (dc_req),
        .cache_grant (dc_grant),
        .jump_valid  (jf_req_valid),
        .jump_req    (jf_req),
        .jump_grant  (jf_grant),
        .ram_valid   (ram_valid),
        .ram_req     (ram_req),
        .credit_ret  (credit_ret)
    );

    burst_ram #(
        .mem_words   (mem_words),
        .queue_depth (queue_depth)
    ) i_burst_ram (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (ram_valid),
        .req        (ram_req),
        .rsp_valid  (mem_valid),
        .rsp        (mem_rsp),
        .credit_ret (credit_ret)
    );

endmodule

`default_nettype wire

// File: tb/ap_cache_checks.svh
`ifndef AP_CACHE_CHECKS_SVH
`define AP_CACHE_CHECKS_SVH

int mismatch_count = 0;
int other_count    = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
        mismatch_count++;
        $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_col(input string name, input col_t got, input col_t exp);
    if (got !== exp)
    begin
        mismatch_count++;
        $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_jmp(input string name, input jaddr_t got, input jaddr_t exp);
    if (got !== exp)
    begin
        mismatch_count++;
        $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

// anything that is not a wrong value
task automatic flag_error(input string what);
    other_count++;
    $display("Error at %0t: %s", $time, what);
endtask

`endif

// File: tb/tb_ap_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ap_cache
    import ap_cache_pkg::*;
();

    localparam int line_words  = 16;
    localparam int mem_words   = 4096;
    localparam int queue_depth = 2;
    localparam int max_vectors = 64;
    localparam int fields      = 6;
    localparam int clk_period  = 10;

    typedef struct packed {
        cache_op_e   op;
        logic [31:0] value;
        logic [15:0] index;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    cache_cmd_t  cmd;
    logic        cmd_rdy;
    logic        rsp_valid;
    word_t       rsp_row;
    col_t        rsp_col;
    jaddr_t      rsp_jmp;

    logic [31:0] vec_mem [fields*max_vectors];
    word_t       ref_mem [mem_words];
    expect_t     pending [$];
    int          n_vectors;
    int          n_responses;
    logic        in_flight;
    logic        loaded;

    `include "ap_cache_checks.svh"

    ap_cache_top #(
        .line_words  (line_words),
        .mem_words   (mem_words),
        .queue_depth (queue_depth)
    ) i_ap_cache_top (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_rdy   (cmd_rdy),
        .rsp_valid (rsp_valid),
        .rsp_row   (rsp_row),
        .rsp_col   (rsp_col),
        .rsp_jmp   (rsp_jmp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int mem_index(input maddr_t a);
        return int'(a) % mem_words;
    endfunction

    function automatic bit returns_data(input cache_op_e op);
        return (op == row_load) || (op == col_load) || (op == jump_load);
    endfunction

    // reference memory holds the logical contents, whatever the cache state
    function automatic logic [31:0] apply_to_model(input cache_cmd_t c);
        maddr_t      base;
        logic [31:0] result;
        base   = c.addr & ~maddr_t'(line_words - 1);
        result = '0;
        case (c.op)
            row_load:
                result = 32'(ref_mem[mem_index(c.addr)]);
            row_store:
                ref_mem[mem_index(c.addr)] = c.row;
            col_load:
                for (int j = 0; j < line_words; j++)
                    result[j] = ref_mem[mem_index(base + maddr_t'(j))][c.bit_sel];
            col_store:
                for (int j = 0; j < line_words; j++)
                    ref_mem[mem_index(base + maddr_t'(j))][c.bit_sel] = c.col[j];
            jump_load:
                result = 32'(ref_mem[mem_index(c.addr)]);
            default:
                ;
        endcase
        return result;
    endfunction

    task automatic load_vectors();
        for (int i = 0; i < fields*max_vectors; i++)
            vec_mem[i] = '1;
        for (int i = 0; i < mem_words; i++)
            ref_mem[i] = '0;
        $readmemh("tb/ap_cache_vectors.txt", vec_mem);
        n_vectors = 0;
        while ((n_vectors < max_vectors) && (vec_mem[fields*n_vectors] != '1))
            n_vectors++;
    endtask

    // called 1 ns after a rising edge, returns at the same point after acceptance
    task automatic run_vector(input int v);
        cache_cmd_t  c;
        logic [31:0] model_exp;
        expect_t     e;
        c.op      = cache_op_e'(vec_mem[fields*v][2:0]);
        c.addr    = maddr_t'(vec_mem[fields*v + 1]);
        c.bit_sel = bit_sel_t'(vec_mem[fields*v + 2]);
        c.row     = word_t'(vec_mem[fields*v + 3]);
        c.col     = col_t'(vec_mem[fields*v + 4]);
        model_exp = apply_to_model(c);
        if (returns_data(c.op) && (vec_mem[fields*v + 5] != model_exp))
            flag_error($sformatf("vector %0d expects 0x%h but the reference model gives 0x%h",
                                 v, vec_mem[fields*v + 5], model_exp));
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        while (!cmd_rdy)
            @(negedge clk);
        @(posedge clk);
        #1;
        e.op    = c.op;
        e.value = model_exp;
        e.index = 16'(v);
        pending.push_back(e);
    endtask

    task automatic check_result(input expect_t e);
        case (e.op)
            row_load:
                check_word($sformatf("rsp_row (vector %0d)", e.index), rsp_row,
                           word_t'(e.value));
            col_load:
                check_col($sformatf("rsp_col (vector %0d)", e.index), rsp_col,
                          col_t'(e.value));
            jump_load:
                check_jmp($sformatf("rsp_jmp (vector %0d)", e.index), rsp_jmp,
                          jaddr_t'(e.value));
            default:
                ;
        endcase
    endtask

    // response monitor, sampled mid-cycle
    always @(negedge clk)
    begin
        expect_t e;
        if (rst)
        begin
            if (in_flight && cmd_rdy)
                flag_error("cmd_rdy is high while a command is still in flight");
            if (rsp_valid)
            begin
                n_responses++;
                if (!in_flight || (pending.size() == 0))
                    flag_error("rsp_valid pulsed with no command in flight");
                else
                begin
                    e = pending.pop_front();
                    check_result(e);
                end
                in_flight = 1'b0;
            end
            if (cmd_valid && cmd_rdy)
                in_flight = 1'b1;
        end
    end

    initial
    begin
        wait (loaded);
        repeat ((n_vectors + 1) * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", (n_vectors + 1) * 200);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        int drain;
        rst         = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        n_responses = 0;
        in_flight   = 1'b0;
        loaded      = 1'b0;
        load_vectors();
        loaded = 1'b1;
        if (n_vectors == 0)
            flag_error("no vectors were read from the stimulus file");
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;
        // cmd_valid stays high from one command to the next
        for (int v = 0; v < n_vectors; v++)
            run_vector(v);
        cmd_valid = 1'b0;
        drain     = 0;
        while ((in_flight || (pending.size() != 0)) && (drain < 1000))
        begin
            @(posedge clk);
            drain++;
        end
        if (n_responses != n_vectors)
            flag_error($sformatf("%0d commands were issued but %0d responses arrived",
                                 n_vectors, n_responses));
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d commands answered",
                 mismatch_count, other_count, n_responses, n_vectors);
        if ((mismatch_count == 0) && (other_count == 0))
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: ap_cache.f
+incdir+tb
src/ap_cache_pkg.sv
src/burst_ram.sv
src/mem_arbiter.sv
src/jump_fetch.sv
src/data_cache.sv
src/ap_cache_top.sv
tb/tb_ap_cache.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, then run and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_ap_cache -f ap_cache.f \
    && ./obj_dir/Vtb_ap_cache | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/ap_cache_vectors.txt
// columns: op addr bit row col expected, all hex, one command per line
// op: 0 row_load, 1 row_store, 2 col_load, 3 col_store, 4 flush, 5 jump_load
// fresh line, then row store and load back
0 0100 0 0000 0000 00000000
1 0103 0 beef 0000 00000000
0 0103 0 0000 0000 0000beef
0 0104 0 0000 0000 00000000
// column store on bit 5, then column and row views of the line
3 0100 5 0000 a5c3 00000000
2 0100 5 0000 0000 0000a5c3
2 010a 0 0000 0000 00000008
0 0103 0 0000 0000 0000becf
0 0100 0 0000 0000 00000020
0 0106 0 0000 0000 00000020
0 010f 0 0000 0000 00000020
// replacement of a dirty line and refill
1 0235 0 1234 0000 00000000
0 0103 0 0000 0000 0000becf
0 0235 0 0000 0000 00001234
1 0237 0 5a5a 0000 00000000
// flush, then jump reads through the shared memory
4 0000 0 0000 0000 00000000
5 0237 0 0000 0000 00005a5a
5 0103 0 0000 0000 0000becf
5 0235 0 0000 0000 00001234
4 0000 0 0000 0000 00000000
1 023f 0 ffff 0000 00000000
0 023f 0 0000 0000 0000ffff
// column store that misses on a dirty line
3 0f80 f 0000 8001 00000000
2 0f8a f 0000 0000 00008001
0 0f80 0 0000 0000 00008000
0 0f8f 0 0000 0000 00008000
0 0f85 0 0000 0000 00000000
4 0000 0 0000 0000 00000000
5 0f8f 0 0000 0000 00008000
5 023f 0 0000 0000 0000ffff
// store miss on a clean line, then swap lines back and forth
1 0ffe 0 7e57 0000 00000000
0 0f81 0 0000 0000 00000000
0 0ffe 0 0000 0000 00007e57
5 0ffe 0 0000 0000 00007e57
2 0500 7 0000 0000 00000000
5 0500 0 0000 0000 00000000
